//--- Bender.yml
package:
  name: rom_loader

sources:
  # packages first, then the loader RTL
  - files:
      - logic/loader_cfg_pkg.sv
      - logic/loader_bus_pkg.sv
      - logic/pif_rom_loader.sv
      - logic/cart_loader.sv
      - logic/load_status.sv
      - logic/rom_loader_top.sv

  # testbench sources, top module tb_rom_loader
  - target: test
    files:
      - verif/tb_clock_gen.sv
      - verif/tb_checker.sv
      - verif/rom_loader_assertions.sv
      - verif/tb_rom_loader.sv

//--- logic/cart_loader.sv
// cartridge loader
// packs pairs of host half-words into 32-bit RAM writes at the
// selected cartridge base and holds the host off with a wait level
// until the RAM acknowledges each write

`timescale 1ns/10ps

module cart_loader
	import loader_cfg_pkg::*, loader_bus_pkg::*;
#(
	parameter logic [RAM_ADDR_W-1:0] CART_MAIN_BASE     = DEF_CART_MAIN_BASE,
	parameter logic [RAM_ADDR_W-1:0] CART_HANDHELD_BASE = DEF_CART_HANDHELD_BASE
) (
	input  logic        clk_1x,
	input  logic        rst_n,
	input  logic        host_download,
	input  logic        ram_ready,
	input  ioctl_beat_t host_beat,
	output ram_wr_t     ram_wr,
	output logic        host_wait,
	output load_flags_t flags
);

	logic                  main_active;
	logic                  handheld_active;
	logic                  cart_active;
	logic [RAM_ADDR_W-1:0] base_sel;
	logic                  wr_strobe;
	logic                  wait_q;
	logic [RAM_ADDR_W-1:0] wr_addr;
	logic [31:0]           wr_data;

	// ======================================================================
	// target select
	// ======================================================================

	// either cartridge download in progress
	assign cart_active = main_active | handheld_active;

	// base follows the registered flag, not the raw index
	assign base_sel = main_active ? CART_MAIN_BASE : CART_HANDHELD_BASE;

	// ======================================================================
	// control: flags, strobe and wait level
	// ======================================================================

	always_ff @(posedge clk_1x) begin
		if (!rst_n) begin
			main_active     <= 1'b0;
			handheld_active <= 1'b0;
			wr_strobe       <= 1'b0;
			wait_q          <= 1'b0;
		end else begin
			main_active <= host_download &
				(host_beat.index[IDX_W-1:0] == IDX_CART_MAIN);
			handheld_active <= host_download &
				(host_beat.index[IDX_W-1:0] == IDX_CART_HANDHELD);

			// single-cycle pulse per finished pair
			wr_strobe <= 1'b0;

			if (cart_active) begin
				if (host_beat.wr && host_beat.addr[1]) begin
					// second half-word in, hold host until RAM answers
					wr_strobe <= 1'b1;
					wait_q    <= 1'b1;
				end else if (ram_ready) begin
					wait_q <= 1'b0;
				end
			end else begin
				// download over, never leave the host stalled
				wait_q <= 1'b0;
			end
		end
	end

	// ======================================================================
	// payload: address and data assembly
	// ======================================================================

	always_ff @(posedge clk_1x) begin
		if (cart_active && host_beat.wr) begin
			if (!host_beat.addr[1]) begin
				// low half first, address wraps within the RAM span
				wr_data[15:0] <= host_beat.dout.half;
				wr_addr       <= host_beat.addr + base_sel;
			end else begin
				wr_data[31:16] <= host_beat.dout.half;
			end
		end
	end

	// word and address stay put while the host waits
	assign ram_wr    = '{strobe: wr_strobe, addr: wr_addr, data: wr_data};
	assign host_wait = wait_q;
	assign flags     = '{main: main_active, handheld: handheld_active};

endmodule

//--- logic/load_status.sv
// load status
// turns the cartridge download flags into the sticky cartridge-loaded
// level, the core reset request and the user LED

`timescale 1ns/10ps

module load_status
	import loader_bus_pkg::*;
(
	input  logic        clk_1x,
	input  logic        rst_n,
	input  logic        ext_reset,
	input  logic        osd_reset,
	input  load_flags_t flags,
	output logic        cart_loaded,
	output logic        core_reset,
	output logic        led_user
);

	// ======================================================================
	// status registers
	// ======================================================================

	always_ff @(posedge clk_1x) begin
		if (!rst_n) begin
			cart_loaded <= 1'b0;
			led_user    <= 1'b0;
			// outside reset sources still pass through
			core_reset  <= ext_reset | osd_reset;
		end else begin
			// a main image stays valid until the next rst_n
			if (flags.main)
				cart_loaded <= 1'b1;

			// core held in reset while the main image streams in
			core_reset <= ext_reset | osd_reset | flags.main;

			// LED lit on any cartridge download
			led_user <= flags.main | flags.handheld;
		end
	end

endmodule

//--- logic/loader_bus_pkg.sv
// loader bus package
// beat, write and flag types passed between the loader modules
// and out to the boot ROM and the cartridge RAM

package loader_bus_pkg;

	import loader_cfg_pkg::*;

	// ======================================================================
	// host beat
	// ======================================================================

	// byte view of one beat, high byte first in the packed order
	typedef struct packed {
		logic [7:0] hi;
		logic [7:0] lo;
	} ioctl_bytes_t;

	// boot-ROM path reads bytes, cartridge path reads the half-word
	typedef union packed {
		logic [15:0]  half;
		ioctl_bytes_t bytes;
	} ioctl_word_u;

	// one host beat, strobe high for a single cycle
	typedef struct packed {
		logic                  wr;
		logic [RAM_ADDR_W-1:0] addr;
		logic [7:0]            index;
		ioctl_word_u           dout;
	} ioctl_beat_t;

	// ======================================================================
	// write ports
	// ======================================================================

	// boot-ROM word write
	typedef struct packed {
		logic                  strobe;
		logic [PIF_ADDR_W-1:0] addr;
		logic [31:0]           data;
	} pif_wr_t;

	// cartridge RAM write, acknowledged later by ram_ready
	typedef struct packed {
		logic                  strobe;
		logic [RAM_ADDR_W-1:0] addr;
		logic [31:0]           data;
	} ram_wr_t;

	// registered download-active levels of the cartridge loader
	typedef struct packed {
		logic main;
		logic handheld;
	} load_flags_t;

endpackage

//--- logic/loader_cfg_pkg.sv
// loader configuration package
// host download index codes, address widths and the default
// memory map used by the boot-ROM and cartridge loaders

package loader_cfg_pkg;

	// ======================================================================
	// download index codes
	// ======================================================================

	// only the low six index bits select the target
	localparam int unsigned IDX_W = 6;

	// boot ROM of the peripheral interface
	localparam logic [IDX_W-1:0] IDX_PIF_ROM = 6'd0;
	// main cartridge image
	localparam logic [IDX_W-1:0] IDX_CART_MAIN = 6'd1;
	// handheld cartridge image
	localparam logic [IDX_W-1:0] IDX_CART_HANDHELD = 6'd2;

	// ======================================================================
	// address widths
	// ======================================================================

	// byte address into the cartridge RAM, 128 MiB span
	localparam int unsigned RAM_ADDR_W = 27;
	// word address into the boot ROM, 1 K words of 32 bits
	localparam int unsigned PIF_ADDR_W = 10;

	// ======================================================================
	// default memory map
	// ======================================================================

	// main cartridge at 16 MiB
	localparam logic [RAM_ADDR_W-1:0] DEF_CART_MAIN_BASE = 27'h100_0000;
	// handheld cartridge at 8 MiB, below the main image
	localparam logic [RAM_ADDR_W-1:0] DEF_CART_HANDHELD_BASE = 27'h080_0000;

endpackage

//--- logic/pif_rom_loader.sv
// boot-ROM loader
// packs pairs of host beats into byte-swapped 32-bit words for the
// peripheral interface boot ROM and strobes one write per word

`timescale 1ns/10ps

module pif_rom_loader
	import loader_cfg_pkg::*, loader_bus_pkg::*;
(
	input  logic        clk_1x,
	input  logic        rst_n,
	input  logic        host_download,
	input  ioctl_beat_t host_beat,
	output pif_wr_t     pif_wr
);

	logic                  rom_active;
	logic                  wr_strobe;
	logic [PIF_ADDR_W-1:0] wr_addr;
	logic [31:0]           wr_data;

	// ======================================================================
	// control: active flag and write strobe
	// ======================================================================

	always_ff @(posedge clk_1x) begin
		if (!rst_n) begin
			rom_active <= 1'b0;
			wr_strobe  <= 1'b0;
		end else begin
			// index bit 6 picks the ROM half, so only the low bits match
			rom_active <= host_download & (host_beat.index[IDX_W-1:0] == IDX_PIF_ROM);
			wr_strobe  <= rom_active & host_beat.wr & host_beat.addr[1];
		end
	end

	// ======================================================================
	// payload: word assembly
	// ======================================================================

	always_ff @(posedge clk_1x) begin
		if (rom_active && host_beat.wr) begin
			if (!host_beat.addr[1]) begin
				// first beat fills the upper half, bytes swapped
				wr_data[31:24] <= host_beat.dout.bytes.lo;
				wr_data[23:16] <= host_beat.dout.bytes.hi;
				wr_addr        <= {host_beat.index[6], host_beat.addr[10:2]};
			end else begin
				// second beat completes the word
				wr_data[15:8] <= host_beat.dout.bytes.lo;
				wr_data[7:0]  <= host_beat.dout.bytes.hi;
			end
		end
	end

	assign pif_wr = '{strobe: wr_strobe, addr: wr_addr, data: wr_data};

endmodule

//--- logic/rom_loader_top.sv
// ROM loader top level
// host download path of the console core: boot-ROM loader,
// cartridge loader with RAM back-pressure, and the status combiner

`timescale 1ns/10ps

module rom_loader_top
	import loader_cfg_pkg::*, loader_bus_pkg::*;
#(
	parameter logic [RAM_ADDR_W-1:0] CART_MAIN_BASE     = DEF_CART_MAIN_BASE,
	parameter logic [RAM_ADDR_W-1:0] CART_HANDHELD_BASE = DEF_CART_HANDHELD_BASE
) (
	input  logic        clk_1x,
	input  logic        rst_n,
	// host download stream
	input  logic        host_download,
	input  ioctl_beat_t host_beat,
	output logic        host_wait,
	// boot ROM write port
	output pif_wr_t     pif_wr,
	// cartridge RAM write port
	output ram_wr_t     ram_wr,
	input  logic        ram_ready,
	// reset sources and status
	input  logic        ext_reset,
	input  logic        osd_reset,
	output logic        cart_loaded,
	output logic        core_reset,
	output logic        led_user
);

	// cartridge flags to the status block
	load_flags_t flags;

	// ======================================================================
	// loaders
	// ======================================================================

	// both loaders watch the same stream, index decides who takes it
	pif_rom_loader pif_rom_loader_inst (
		.clk_1x        (clk_1x),
		.rst_n         (rst_n),
		.host_download (host_download),
		.host_beat     (host_beat),
		.pif_wr        (pif_wr)
	);

	cart_loader #(
		.CART_MAIN_BASE     (CART_MAIN_BASE),
		.CART_HANDHELD_BASE (CART_HANDHELD_BASE)
	) cart_loader_inst (
		.clk_1x        (clk_1x),
		.rst_n         (rst_n),
		.host_download (host_download),
		.ram_ready     (ram_ready),
		.host_beat     (host_beat),
		.ram_wr        (ram_wr),
		.host_wait     (host_wait),
		.flags         (flags)
	);

	// ======================================================================
	// status
	// ======================================================================

	load_status load_status_inst (
		.clk_1x      (clk_1x),
		.rst_n       (rst_n),
		.ext_reset   (ext_reset),
		.osd_reset   (osd_reset),
		.flags       (flags),
		.cart_loaded (cart_loaded),
		.core_reset  (core_reset),
		.led_user    (led_user)
	);

endmodule

//--- rom_loader_top.f
logic/loader_cfg_pkg.sv
logic/loader_bus_pkg.sv
logic/pif_rom_loader.sv
logic/cart_loader.sv
logic/load_status.sv
logic/rom_loader_top.sv
verif/tb_clock_gen.sv
verif/tb_checker.sv
verif/rom_loader_assertions.sv
verif/tb_rom_loader.sv

//--- verif/rom_loader_assertions.sv
// cartridge write assertions
// concurrent checks on the RAM write strobe and the host wait level,
// bound into the cartridge loader

`timescale 1ns/10ps

module rom_loader_assertions
	import loader_bus_pkg::*;
(
	input logic    clk_1x,
	input logic    rst_n,
	input ram_wr_t ram_wr,
	input logic    host_wait
);

	int unsigned fail_count = 0;

	// strobe is a single-cycle pulse
	strobe_one_cycle: assert property (@(posedge clk_1x) disable iff (!rst_n)
		ram_wr.strobe |=> !ram_wr.strobe)
	else begin
		$error("ram_wr strobe held longer than one cycle");
		fail_count++;
	end

	// wait goes up only together with a write
	wait_with_strobe: assert property (@(posedge clk_1x) disable iff (!rst_n)
		(ram_wr.strobe |-> host_wait) and ($rose(host_wait) |-> ram_wr.strobe))
	else begin
		$error("host_wait did not rise together with the ram_wr strobe");
		fail_count++;
	end

	// host held off, so no new write
	no_strobe_in_wait: assert property (@(posedge clk_1x) disable iff (!rst_n)
		ram_wr.strobe |-> !$past(host_wait))
	else begin
		$error("ram_wr strobe fired while host_wait was already high");
		fail_count++;
	end

endmodule

//--- verif/tb_checker.sv
// write and status checker
// compares boot-ROM and RAM writes with queued expected writes,
// checks status levels on request and flags a run that hangs

`timescale 1ns/10ps

module tb_checker
	import loader_bus_pkg::*;
#(
	parameter int unsigned TIMEOUT_CYCLES = 1000
) (
	input  logic        clk_1x,
	input  logic        rst_n,
	input  pif_wr_t     pif_wr,
	input  ram_wr_t     ram_wr,
	input  logic        host_wait,
	input  logic        cart_loaded,
	input  logic        core_reset,
	input  logic        led_user,
	output logic        timed_out,
	output int unsigned tests_run,
	output int unsigned tests_failed,
	output int unsigned error_total
);

	// expected writes, {address, data}
	logic [58:0] pif_q [$];
	logic [58:0] ram_q [$];
	logic [58:0] exp_item;

	string       cur_test = "reset";
	int unsigned test_errs = 0;
	int unsigned cycles = 0;

	initial begin
		timed_out    = 1'b0;
		tests_run    = 0;
		tests_failed = 0;
		error_total  = 0;
	end

	// ======================================================================
	// calls from the test sequence
	// ======================================================================

	task automatic start_test(input string name);
		cur_test  = name;
		test_errs = 0;
	endtask

	task automatic expect_pif(input logic [26:0] addr, input logic [31:0] data);
		pif_q.push_back({17'd0, addr[9:0], data});
	endtask

	task automatic expect_ram(input logic [26:0] addr, input logic [31:0] data);
		ram_q.push_back({addr, data});
	endtask

	task automatic note_error();
		error_total++;
		test_errs++;
	endtask

	task automatic check_level(input string what, input logic expected);
		logic actual;
		case (what)
			"core_reset":  actual = core_reset;
			"led_user":    actual = led_user;
			"cart_loaded": actual = cart_loaded;
			default:       actual = host_wait;
		endcase
		if (actual !== expected) begin
			$display("Fail %s %s: expected %b, actual %b", cur_test, what, expected, actual);
			note_error();
		end
	endtask

	// leftover expected writes count as one failure
	task automatic end_test();
		if (pif_q.size() != 0 || ram_q.size() != 0) begin
			$display("%s: %0d boot-ROM and %0d RAM writes never came out",
				cur_test, pif_q.size(), ram_q.size());
			note_error();
			pif_q.delete();
			ram_q.delete();
		end
		tests_run++;
		if (test_errs == 0) begin
			$display("test %s passed", cur_test);
		end else begin
			tests_failed++;
			$display("test %s failed with %0d errors", cur_test, test_errs);
		end
	endtask

	task automatic compare_write(input string port, input logic [58:0] expected,
		input logic [58:0] actual);
		if (expected !== actual) begin
			$display("Fail %s %s: expected addr %h data %h, actual addr %h data %h",
				cur_test, port, expected[58:32], expected[31:0], actual[58:32], actual[31:0]);
			note_error();
		end
	endtask

	// ======================================================================
	// write monitor, outputs settled on the falling edge
	// ======================================================================

	always @(negedge clk_1x) begin
		if (rst_n && pif_wr.strobe) begin
			if (pif_q.size() == 0) begin
				$display("%s: boot-ROM write at %h came with none expected", cur_test, pif_wr.addr);
				note_error();
			end else begin
				exp_item = pif_q.pop_front();
				compare_write("pif_wr", exp_item, {17'd0, pif_wr.addr, pif_wr.data});
			end
		end
		if (rst_n && ram_wr.strobe) begin
			if (ram_q.size() == 0) begin
				$display("%s: RAM write at %h came with none expected", cur_test, ram_wr.addr);
				note_error();
			end else begin
				exp_item = ram_q.pop_front();
				compare_write("ram_wr", exp_item, {ram_wr.addr, ram_wr.data});
			end
		end
	end

	// cycle limit for the whole run
	always @(posedge clk_1x) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES)
			timed_out = 1'b1;
	end

endmodule

//--- verif/tb_clock_gen.sv
// testbench clock and reset
// free-running clk_1x with an 8 ns period, rst_n held low for the
// first cycles and released on a falling edge

`timescale 1ns/10ps

module tb_clock_gen #(
	parameter int unsigned RESET_CYCLES = 16
) (
	output logic clk_1x,
	output logic rst_n
);

	initial begin
		clk_1x = 1'b0;
		forever #4 clk_1x = ~clk_1x;
	end

	// release away from the sampling edge
	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk_1x);
		@(negedge clk_1x);
		rst_n = 1'b1;
	end

endmodule

//--- verif/tb_rom_loader.sv
// ROM loader testbench top
// drives host download beats from a test table, answers RAM writes
// after random delays and hands expected writes to the checker

`timescale 1ns/10ps

module tb_rom_loader
	import loader_cfg_pkg::*, loader_bus_pkg::*;
();

	typedef struct packed {
		logic [7:0]  index;
		logic [26:0] start;
		logic [4:0]  first;
		logic [4:0]  count;
		logic [26:0] exp_addr;
		logic [1:0]  src;
		logic        core;
		logic        led;
		logic        loaded;
	} test_row_t;

	localparam int N_TESTS = 7;
	// beats sent over all tests, boot-ROM pool used twice
	localparam int BEATS_SENT = 24;
	localparam int unsigned TIMEOUT_CYCLES = BEATS_SENT * 12 + 200;

	// ======================================================================
	// test table
	// ======================================================================

	string test_name [N_TESTS] = '{"pif_low", "pif_high", "cart_handheld", "cart_main",
		"back_pressure", "ext_reset", "osd_reset"};

	// index, start, first beat, beat count, first write addr, reset source,
	// core_reset and led_user during, cart_loaded after
	test_row_t test_table [N_TESTS] = '{
		'{8'h00, 27'h000_0010, 5'd0,  5'd4, 27'h000_0004, 2'b00, 1'b0, 1'b0, 1'b0},
		'{8'h40, 27'h000_0010, 5'd0,  5'd4, 27'h000_0204, 2'b00, 1'b0, 1'b0, 1'b0},
		'{8'h02, 27'h000_0200, 5'd4,  5'd4, 27'h080_0200, 2'b00, 1'b0, 1'b1, 1'b0},
		'{8'h01, 27'h000_0100, 5'd8,  5'd4, 27'h100_0100, 2'b00, 1'b1, 1'b1, 1'b1},
		'{8'h01, 27'h6ff_fff8, 5'd12, 5'd8, 27'h7ff_fff8, 2'b00, 1'b1, 1'b1, 1'b1},
		'{8'h3f, 27'h000_0000, 5'd0,  5'd0, 27'h000_0000, 2'b01, 1'b1, 1'b0, 1'b1},
		'{8'h3f, 27'h000_0000, 5'd0,  5'd0, 27'h000_0000, 2'b10, 1'b1, 1'b0, 1'b1}
	};

	// back_pressure crosses the top of the RAM and wraps to 0
	logic [15:0] beat_pool [20] = '{
		16'h1234, 16'h5678, 16'h9abc, 16'hdef0,
		16'ha55a, 16'h0ff0, 16'hc3c3, 16'h3c3c,
		16'h0102, 16'h0304, 16'hfedc, 16'hba98,
		16'h1111, 16'h2222, 16'h3333, 16'h4444,
		16'h8001, 16'h7ffe, 16'h00aa, 16'hbb00
	};

	logic        clk_1x;
	logic        rst_n;
	logic        host_download;
	ioctl_beat_t host_beat;
	logic        ram_ready;
	logic        ext_reset;
	logic        osd_reset;
	logic        host_wait;
	pif_wr_t     pif_wr;
	ram_wr_t     ram_wr;
	logic        cart_loaded;
	logic        core_reset;
	logic        led_user;
	logic        timed_out;
	int unsigned tests_run;
	int unsigned tests_failed;
	int unsigned error_total;
	int unsigned assert_fails;
	int unsigned ready_delay;
	logic        ready_pending;

	tb_clock_gen #(.RESET_CYCLES(16)) tb_clock_gen_inst (.clk_1x(clk_1x), .rst_n(rst_n));

	rom_loader_top rom_loader_top_inst (
		.clk_1x(clk_1x), .rst_n(rst_n), .host_download(host_download),
		.host_beat(host_beat), .host_wait(host_wait), .pif_wr(pif_wr),
		.ram_wr(ram_wr), .ram_ready(ram_ready), .ext_reset(ext_reset),
		.osd_reset(osd_reset), .cart_loaded(cart_loaded), .core_reset(core_reset),
		.led_user(led_user)
	);

	tb_checker #(.TIMEOUT_CYCLES(TIMEOUT_CYCLES)) checker_inst (
		.clk_1x(clk_1x), .rst_n(rst_n), .pif_wr(pif_wr), .ram_wr(ram_wr),
		.host_wait(host_wait), .cart_loaded(cart_loaded), .core_reset(core_reset),
		.led_user(led_user), .timed_out(timed_out), .tests_run(tests_run),
		.tests_failed(tests_failed), .error_total(error_total)
	);

	bind cart_loader rom_loader_assertions assertions_inst (
		.clk_1x(clk_1x), .rst_n(rst_n), .ram_wr(ram_wr), .host_wait(host_wait)
	);

	// boot-ROM word: each beat byte-swapped, first beat on top
	function automatic logic [31:0] rom_word(input logic [15:0] b0, input logic [15:0] b1);
		return {b0[7:0], b0[15:8], b1[7:0], b1[15:8]};
	endfunction

	// ======================================================================
	// host driver, one table row per call
	// ======================================================================

	task automatic run_test(input int t);
		test_row_t   row;
		int          k;
		logic [15:0] b0;
		logic [15:0] b1;
		row = test_table[t];
		checker_inst.start_test(test_name[t]);
		for (k = 0; k < row.count; k += 2) begin
			b0 = beat_pool[row.first + k];
			b1 = beat_pool[row.first + k + 1];
			if (row.index[5:0] == IDX_PIF_ROM)
				checker_inst.expect_pif(row.exp_addr + 27'(k / 2), rom_word(b0, b1));
			else
				checker_inst.expect_ram(row.exp_addr + 27'(2 * k), {b1, b0});
		end
		if (row.count == 0) begin
			// reset sources alone, no download
			ext_reset = row.src[0];
			osd_reset = row.src[1];
			repeat (2) @(negedge clk_1x);
			checker_inst.check_level("core_reset", row.core);
			checker_inst.check_level("led_user", row.led);
			ext_reset = 1'b0;
			osd_reset = 1'b0;
			repeat (2) @(negedge clk_1x);
			checker_inst.check_level("core_reset", 1'b0);
		end else begin
			host_download   = 1'b1;
			host_beat.index = row.index;
			repeat (2) @(negedge clk_1x);
			for (k = 0; k < row.count; k++) begin
				// next beat only once the RAM has answered
				while (host_wait)
					@(negedge clk_1x);
				host_beat.wr        = 1'b1;
				host_beat.addr      = row.start + 27'(2 * k);
				host_beat.dout.half = beat_pool[row.first + k];
				@(negedge clk_1x);
				host_beat.wr = 1'b0;
			end
			checker_inst.check_level("core_reset", row.core);
			checker_inst.check_level("led_user", row.led);
			// download ends with the last RAM write still unanswered
			host_download = 1'b0;
			repeat (3) @(negedge clk_1x);
			checker_inst.check_level("host_wait", 1'b0);
			// last acknowledge done before the next test
			while (ready_pending)
				@(negedge clk_1x);
		end
		checker_inst.check_level("cart_loaded", row.loaded);
		checker_inst.end_test();
	endtask

	// RAM acknowledge after 1 to 6 cycles
	initial begin
		void'($urandom(32'h00cc8079));
		forever begin
			@(negedge clk_1x);
			if (ram_wr.strobe) begin
				ready_pending = 1'b1;
				ready_delay = $urandom % 6 + 1;
				repeat (ready_delay) @(negedge clk_1x);
				ram_ready = 1'b1;
				@(negedge clk_1x);
				ram_ready = 1'b0;
				ready_pending = 1'b0;
			end
		end
	end

	initial begin
		host_download = 1'b0;
		host_beat     = '0;
		ram_ready     = 1'b0;
		ext_reset     = 1'b0;
		osd_reset     = 1'b0;
		ready_pending = 1'b0;
		wait (rst_n === 1'b1);
		@(negedge clk_1x);
		for (int t = 0; t < N_TESTS; t++)
			run_test(t);
		repeat (4) @(negedge clk_1x);
		assert_fails = rom_loader_top_inst.cart_loader_inst.assertions_inst.fail_count;
		$display("tests run %0d, tests failed %0d, check errors %0d, assertion failures %0d",
			tests_run, tests_failed, error_total, assert_fails);
		if (tests_failed == 0 && error_total == 0 && assert_fails == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

	initial begin
		wait (timed_out === 1'b1);
		$display("run stopped after %0d cycles without finishing", TIMEOUT_CYCLES);
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule
